/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - common/fetch_pkg.sv
  - design/inst_predecode.sv
  - design/fetch_pc.sv
  - icache/icache_way.sv
  - icache/icache_way_select.sv
  - icache/icache_ctrl.sv
  - icache/icache.sv
  - design/fetch_top.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/fetch_tb.sv

/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // ============================================================
  // Core and memory map
  // ============================================================
  localparam int unsigned XLEN = 32;
  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0100;
  // Executable region, anything outside is an access fault
  localparam logic [XLEN-1:0] EXEC_BASE = 32'h0000_0000;
  localparam logic [XLEN-1:0] EXEC_SIZE = 32'h0000_4000;

  // ============================================================
  // Instruction cache geometry
  // ============================================================
  localparam int unsigned IC_WAYS = 2;
  localparam int unsigned IC_SETS = 8;
  localparam int unsigned LINE_WORDS = 2;
  localparam int unsigned LINE_W = LINE_WORDS * XLEN;
  localparam int unsigned IDX_W = $clog2(IC_SETS);
  // Byte offset inside a line
  localparam int unsigned OFS_W = $clog2(LINE_WORDS * 4);
  localparam int unsigned TAG_W = XLEN - IDX_W - OFS_W;
  localparam int unsigned WORD_W = $clog2(LINE_WORDS);
  localparam int unsigned WAY_W = $clog2(IC_WAYS);

  // Fixed SYSTEM encodings
  localparam logic [XLEN-1:0] ECALL_INSN = 32'h0000_0073;
  localparam logic [XLEN-1:0] EBREAK_INSN = 32'h0010_0073;
  localparam logic [XLEN-1:0] MRET_INSN = 32'h3020_0073;
  localparam logic [XLEN-1:0] WFI_INSN = 32'h1050_0073;

  typedef enum logic [2:0] {
    NO_EXC,
    INSTR_MISALIGNED,
    INSTR_ACCESS_FAULT,
    ILLEGAL_INSTR,
    EBREAK,
    ECALL
  } exc_type_e;

  typedef enum logic [1:0] {
    KIND_NORMAL,
    KIND_ILLEGAL,
    KIND_EBREAK,
    KIND_ECALL
  } instr_kind_e;

  // ============================================================
  // Bundles between blocks
  // ============================================================
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } cache_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] instr;
    logic            bus_err;
  } cache_rsp_t;

  typedef struct packed {
    logic              we;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [LINE_W-1:0] line;
  } way_fill_t;

  typedef struct packed {
    logic              hit;
    logic [LINE_W-1:0] line;
  } way_rd_t;

  // Read-only manager, pwrite is tied low at the bus
  typedef struct packed {
    logic            psel;
    logic            penable;
    logic [XLEN-1:0] paddr;
  } apb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    exc_type_e       exc;
  } fetch_out_t;

endpackage

`default_nettype wire

/* design/fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            stall_i,
  input  logic                            flush_i,
  input  logic [fetch_pkg::XLEN-1:0]      flush_pc_i,
  input  logic                            trap_i,
  input  logic [fetch_pkg::XLEN-1:0]      mtvec_i,
  input  logic                            redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]      redirect_pc_i,
  output fetch_pkg::cache_req_t           cache_req_o,
  input  fetch_pkg::cache_rsp_t           cache_rsp_i,
  output fetch_pkg::fetch_out_t           out_o
);

  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic [fetch_pkg::XLEN-1:0] pc_next;
  logic                       pc_en;
  logic                       misaligned;
  logic                       out_of_region;
  logic                       early_fault;
  fetch_pkg::instr_kind_e     kind;

  // ============================================================
  // Address checks on the current PC
  // ============================================================
  assign misaligned = pc_q[1:0] != 2'b00;
  // Unsigned distance from the base also catches addresses below it
  assign out_of_region = (pc_q - fetch_pkg::EXEC_BASE) >= fetch_pkg::EXEC_SIZE;
  assign early_fault = misaligned || out_of_region;

  // Faulting PCs never reach the cache
  assign cache_req_o.valid = !early_fault;
  assign cache_req_o.addr  = pc_q;

  // ============================================================
  // Output word and predecode
  // ============================================================
  assign out_o.valid = early_fault || cache_rsp_i.valid;
  assign out_o.pc    = pc_q;
  assign out_o.instr = early_fault ? '0 : cache_rsp_i.instr;

  inst_predecode u_predecode (
    .instr_i (out_o.instr),
    .kind_o  (kind)
  );

  // Highest priority first, fetch faults mask any decode result
  always_comb begin
    if (misaligned) begin
      out_o.exc = fetch_pkg::INSTR_MISALIGNED;
    end else if (out_of_region) begin
      out_o.exc = fetch_pkg::INSTR_ACCESS_FAULT;
    end else if (!cache_rsp_i.valid) begin
      out_o.exc = fetch_pkg::NO_EXC;
    end else if (cache_rsp_i.bus_err) begin
      out_o.exc = fetch_pkg::INSTR_ACCESS_FAULT;
    end else begin
      case (kind)
        fetch_pkg::KIND_ILLEGAL: out_o.exc = fetch_pkg::ILLEGAL_INSTR;
        fetch_pkg::KIND_EBREAK:  out_o.exc = fetch_pkg::EBREAK;
        fetch_pkg::KIND_ECALL:   out_o.exc = fetch_pkg::ECALL;
        default:                 out_o.exc = fetch_pkg::NO_EXC;
      endcase
    end
  end

  // ============================================================
  // Next PC selection
  // ============================================================
  // Control transfers load at once, even under stall or a miss
  assign pc_en = flush_i || trap_i || redirect_i || (out_o.valid && !stall_i);

  always_comb begin
    if (flush_i) begin
      pc_next = flush_pc_i;
    end else if (trap_i) begin
      pc_next = mtvec_i;
    end else if (redirect_i) begin
      pc_next = redirect_pc_i;
    end else begin
      // Sequential fetch, no compressed support
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q <= fetch_pkg::RESET_VECTOR;
    end else if (pc_en) begin
      pc_q <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       stall_i,
  input  logic                       flush_i,
  input  logic [fetch_pkg::XLEN-1:0] flush_pc_i,
  input  logic                       trap_i,
  input  logic [fetch_pkg::XLEN-1:0] mtvec_i,
  input  logic                       redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  output fetch_pkg::fetch_out_t      out_o,
  output fetch_pkg::apb_req_t        apb_req_o,
  input  fetch_pkg::apb_rsp_t        apb_rsp_i
);

  fetch_pkg::cache_req_t cache_req;
  fetch_pkg::cache_rsp_t cache_rsp;

  // PC unit with predecode and exception merge
  fetch_pc u_pc (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall_i),
    .flush_i       (flush_i),
    .flush_pc_i    (flush_pc_i),
    .trap_i        (trap_i),
    .mtvec_i       (mtvec_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .cache_req_o   (cache_req),
    .cache_rsp_i   (cache_rsp),
    .out_o         (out_o)
  );

  // Two-way cache, fills over APB
  icache u_icache (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (cache_req),
    .rsp_o     (cache_rsp),
    .apb_req_o (apb_req_o),
    .apb_rsp_i (apb_rsp_i)
  );

endmodule

`default_nettype wire

/* design/inst_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_predecode (
  input  logic [fetch_pkg::XLEN-1:0] instr_i,
  output fetch_pkg::instr_kind_e     kind_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // RV32I opcode map with the fixed fields that matter
  always_comb begin
    case (opcode)
      // LUI, AUIPC, JAL and FENCE
      7'b0110111, 7'b0010111, 7'b1101111, 7'b0001111: legal = 1'b1;
      7'b1100111: legal = funct3 == 3'b000;
      // Branches, funct3 2 and 3 are reserved
      7'b1100011: legal = (funct3 != 3'b010) && (funct3 != 3'b011);
      7'b0000011: legal = (funct3 != 3'b011) && (funct3 < 3'b110);
      7'b0100011: legal = funct3 <= 3'b010;
      7'b0010011: begin
        // Immediate shifts carry a funct7 field
        if (funct3 == 3'b001) begin
          legal = funct7 == 7'b0000000;
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          legal = 1'b1;
        end
      end
      7'b0110011: begin
        // Only ADD/SUB and SRL/SRA have the alternate funct7
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      7'b1110011: begin
        // funct3 0 holds the privileged words, 4 is reserved, the rest are CSRs
        if (funct3 == 3'b000) begin
          legal = (instr_i == fetch_pkg::MRET_INSN) || (instr_i == fetch_pkg::WFI_INSN);
        end else begin
          legal = funct3 != 3'b100;
        end
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    if (instr_i == fetch_pkg::ECALL_INSN) begin
      kind_o = fetch_pkg::KIND_ECALL;
    end else if (instr_i == fetch_pkg::EBREAK_INSN) begin
      kind_o = fetch_pkg::KIND_EBREAK;
    end else if ((instr_i[1:0] != 2'b11) || (instr_i == '0) || (instr_i == '1) || !legal) begin
      // 16-bit encodings land here as well
      kind_o = fetch_pkg::KIND_ILLEGAL;
    end else begin
      kind_o = fetch_pkg::KIND_NORMAL;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
common/fetch_pkg.sv
design/inst_predecode.sv
design/fetch_pc.sv
icache/icache_way.sv
icache/icache_way_select.sv
icache/icache_ctrl.sv
icache/icache.sv
design/fetch_top.sv
testbench/tb_clock.sv
testbench/fetch_tb.sv

/* icache/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fetch_pkg::cache_req_t req_i,
  output fetch_pkg::cache_rsp_t rsp_o,
  output fetch_pkg::apb_req_t   apb_req_o,
  input  fetch_pkg::apb_rsp_t   apb_rsp_i
);

  fetch_pkg::way_fill_t            fill;
  fetch_pkg::way_rd_t              rd [fetch_pkg::IC_WAYS];
  logic                            fill_done;
  logic                            hit;
  logic [fetch_pkg::XLEN-1:0]      word;
  logic [fetch_pkg::XLEN-1:0]      look_addr;
  logic [fetch_pkg::WAY_W-1:0]     victim;

  // While a line is written the ways and selector index the fill set,
  // so the victim read and its advance refer to the same set
  assign look_addr = fill.we ? {fill.tag, fill.idx, {fetch_pkg::OFS_W{1'b0}}} : req_i.addr;

  icache_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .hit_i       (hit),
    .word_i      (word),
    .fill_o      (fill),
    .fill_done_o (fill_done),
    .rsp_o       (rsp_o),
    .apb_req_o   (apb_req_o),
    .apb_rsp_i   (apb_rsp_i)
  );

  for (genvar gv = 0; gv < fetch_pkg::IC_WAYS; gv++) begin : g_way
    icache_way u_way (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .addr_i     (look_addr),
      .fill_i     (fill),
      .fill_sel_i (victim == fetch_pkg::WAY_W'(gv)),
      .rd_o       (rd[gv])
    );
  end

  icache_way_select u_select (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .addr_i      (look_addr),
    .rd_i        (rd),
    .fill_done_i (fill_done),
    .hit_o       (hit),
    .word_o      (word),
    .victim_o    (victim)
  );

endmodule

`default_nettype wire

/* icache/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  fetch_pkg::cache_req_t      req_i,
  input  logic                       hit_i,
  input  logic [fetch_pkg::XLEN-1:0] word_i,
  output fetch_pkg::way_fill_t       fill_o,
  output logic                       fill_done_o,
  output fetch_pkg::cache_rsp_t      rsp_o,
  output fetch_pkg::apb_req_t        apb_req_o,
  input  fetch_pkg::apb_rsp_t        apb_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    WRITE
  } state_e;

  state_e                                              state_q;
  logic [fetch_pkg::XLEN-fetch_pkg::OFS_W-1:0]         line_q;
  logic [fetch_pkg::WORD_W-1:0]                        cnt_q;
  logic [fetch_pkg::LINE_W-1:0]                        buf_q;
  logic                                                err_q;
  logic                                                miss;
  logic                                                same_line;
  logic                                                last_word;

  assign miss      = req_i.valid && !hit_i;
  assign same_line = req_i.addr[fetch_pkg::XLEN-1:fetch_pkg::OFS_W] == line_q;
  assign last_word = cnt_q == fetch_pkg::WORD_W'(fetch_pkg::LINE_WORDS - 1);

  // ============================================================
  // Line fill FSM
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss) begin
            cnt_q   <= '0;
            err_q   <= 1'b0;
            state_q <= SETUP;
          end
        end
        // One setup cycle per word
        SETUP: state_q <= ACCESS;
        ACCESS: begin
          if (apb_rsp_i.pready) begin
            if (apb_rsp_i.pslverr) begin
              // Abort the line, nothing gets written
              err_q   <= 1'b1;
              state_q <= WRITE;
            end else if (last_word) begin
              state_q <= WRITE;
            end else begin
              cnt_q   <= cnt_q + 1'b1;
              state_q <= SETUP;
            end
          end
        end
        WRITE:   state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Line address and collected words
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && miss) begin
      line_q <= req_i.addr[fetch_pkg::XLEN-1:fetch_pkg::OFS_W];
    end
    if ((state_q == ACCESS) && apb_rsp_i.pready) begin
      buf_q[fetch_pkg::XLEN*cnt_q +: fetch_pkg::XLEN] <= apb_rsp_i.prdata;
    end
  end

  // ============================================================
  // APB manager, words in ascending order from the line base
  // ============================================================
  assign apb_req_o.psel    = (state_q == SETUP) || (state_q == ACCESS);
  assign apb_req_o.penable = state_q == ACCESS;
  assign apb_req_o.paddr   = {line_q, cnt_q, 2'b00};

  // Line write one cycle after the last pready
  assign fill_o.we    = (state_q == WRITE) && !err_q;
  assign fill_o.idx   = line_q[fetch_pkg::IDX_W-1:0];
  assign fill_o.tag   = line_q[fetch_pkg::XLEN-fetch_pkg::OFS_W-1:fetch_pkg::IDX_W];
  assign fill_o.line  = buf_q;
  assign fill_done_o  = fill_o.we;

  always_comb begin
    rsp_o = '0;
    if (state_q == WRITE) begin
      // Lookup points at the fill line here, so only a bus error answers,
      // and only while the faulting line is still requested
      rsp_o.valid   = err_q && req_i.valid && same_line;
      rsp_o.bus_err = err_q && req_i.valid && same_line;
    end else begin
      rsp_o.valid = req_i.valid && hit_i;
      rsp_o.instr = word_i;
    end
  end

endmodule

`default_nettype wire

/* icache/icache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [fetch_pkg::XLEN-1:0] addr_i,
  input  fetch_pkg::way_fill_t       fill_i,
  input  logic                       fill_sel_i,
  output fetch_pkg::way_rd_t         rd_o
);

  logic [fetch_pkg::IC_SETS-1:0] valid_q;
  logic [fetch_pkg::TAG_W-1:0]   tag_q  [fetch_pkg::IC_SETS];
  logic [fetch_pkg::LINE_W-1:0]  line_q [fetch_pkg::IC_SETS];
  logic [fetch_pkg::IDX_W-1:0]   idx;
  logic                          wr;

  assign idx = addr_i[fetch_pkg::OFS_W +: fetch_pkg::IDX_W];
  // Written only when this way is the victim
  assign wr  = fill_i.we && fill_sel_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (wr) begin
      valid_q[fill_i.idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr) begin
      tag_q[fill_i.idx]  <= fill_i.tag;
      line_q[fill_i.idx] <= fill_i.line;
    end
  end

  // Combinational lookup
  assign rd_o.hit  = valid_q[idx] && (tag_q[idx] == addr_i[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W]);
  assign rd_o.line = line_q[idx];

endmodule

`default_nettype wire

/* icache/icache_way_select.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way_select (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [fetch_pkg::XLEN-1:0]  addr_i,
  input  fetch_pkg::way_rd_t          rd_i [fetch_pkg::IC_WAYS],
  input  logic                        fill_done_i,
  output logic                        hit_o,
  output logic [fetch_pkg::XLEN-1:0]  word_o,
  output logic [fetch_pkg::WAY_W-1:0] victim_o
);

  logic [fetch_pkg::WAY_W-1:0]  victim_q [fetch_pkg::IC_SETS];
  logic [fetch_pkg::LINE_W-1:0] line;
  logic [fetch_pkg::IDX_W-1:0]  idx;
  logic [fetch_pkg::WORD_W-1:0] word_idx;

  assign idx      = addr_i[fetch_pkg::OFS_W +: fetch_pkg::IDX_W];
  assign word_idx = addr_i[2 +: fetch_pkg::WORD_W];

  // At most one way hits, so an OR merge is enough
  always_comb begin
    hit_o = 1'b0;
    line  = '0;
    for (int w = 0; w < fetch_pkg::IC_WAYS; w++) begin
      hit_o = hit_o | rd_i[w].hit;
      if (rd_i[w].hit) begin
        line = line | rd_i[w].line;
      end
    end
  end

  assign word_o   = line[fetch_pkg::XLEN*word_idx +: fetch_pkg::XLEN];
  assign victim_o = victim_q[idx];

  // Round-robin pointer per set, steps on each completed fill
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < fetch_pkg::IC_SETS; s++) begin
        victim_q[s] <= '0;
      end
    end else if (fill_done_i) begin
      if (victim_q[idx] == fetch_pkg::WAY_W'(fetch_pkg::IC_WAYS - 1)) begin
        victim_q[idx] <= '0;
      end else begin
        victim_q[idx] <= victim_q[idx] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  typedef logic [fetch_pkg::XLEN-1:0] word_t;

  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned NUM_TESTS   = 6;
  localparam int unsigned TEST_CYCLES = 400;
  localparam int unsigned WAIT_LIMIT  = 64;
  localparam int unsigned RNG_SEED    = 32'ha92e_03c3;

  // Memory overrides
  localparam word_t ECALL_ADDR  = 32'h0000_0800;
  localparam word_t EBREAK_ADDR = 32'h0000_0808;
  localparam word_t C16_ADDR    = 32'h0000_0810;
  localparam word_t ERR_ADDR    = 32'h0000_0c00;

  // Address step between lines of the same set
  localparam int unsigned SET_STRIDE = fetch_pkg::IC_SETS * fetch_pkg::LINE_WORDS * 4;

  logic                  clk;
  logic                  rst_n;
  logic                  stall;
  logic                  flush;
  word_t                 flush_pc;
  logic                  trap;
  word_t                 mtvec;
  logic                  redirect;
  word_t                 redirect_pc;
  fetch_pkg::fetch_out_t out;
  fetch_pkg::apb_req_t   apb_req;
  fetch_pkg::apb_rsp_t   apb_rsp = '0;

  int xfer_count = 0;
  int errors = 0;
  int checks = 0;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (5)
  ) u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  fetch_top DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .stall_i       (stall),
    .flush_i       (flush),
    .flush_pc_i    (flush_pc),
    .trap_i        (trap),
    .mtvec_i       (mtvec),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .out_o         (out),
    .apb_req_o     (apb_req),
    .apb_rsp_i     (apb_rsp)
  );

  // ============================================================
  // Reference model of memory and decode
  // ============================================================
  function automatic word_t mem_word(input word_t addr);
    case (addr)
      ECALL_ADDR:  return 32'h0000_0073;
      EBREAK_ADDR: return 32'h0010_0073;
      // c.li a0, 0 in the low half
      C16_ADDR:    return 32'h0000_4501;
      default:     return addr ^ 32'h0000_0013;
    endcase
  endfunction

  // RV32I legality from the ISA tables
  function automatic fetch_pkg::exc_type_e decode_exc(input word_t w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
      7'h37, 7'h17, 7'h6f, 7'h0f: ok = 1'b1;
      7'h67: ok = (f3 == 3'd0);
      7'h63: ok = (f3 != 3'd2) && (f3 != 3'd3);
      7'h03: ok = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
      7'h23: ok = (f3 <= 3'd2);
      7'h13: ok = (f3 == 3'd1) ? (f7 == 7'h00) :
                  (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
      7'h33: ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      // funct3 zero only takes the fixed privileged words
      7'h73: ok = (f3 == 3'd0) ? ((w == 32'h3020_0073) || (w == 32'h1050_0073)) :
                  (f3 != 3'd4);
      default: ok = 1'b0;
    endcase
    if (w == 32'h0000_0073) begin
      return fetch_pkg::ECALL;
    end else if (w == 32'h0010_0073) begin
      return fetch_pkg::EBREAK;
    end else if ((w == '0) || (w == '1) || !ok) begin
      return fetch_pkg::ILLEGAL_INSTR;
    end
    return fetch_pkg::NO_EXC;
  endfunction

  // Expected output for a fetch at pc
  function automatic fetch_pkg::fetch_out_t expect_fetch(input word_t pc);
    fetch_pkg::fetch_out_t e;
    e       = '0;
    e.valid = 1'b1;
    e.pc    = pc;
    if (pc[1:0] != 2'b00) begin
      e.exc = fetch_pkg::INSTR_MISALIGNED;
    end else if (pc >= 32'h0000_4000) begin
      // Executable region is the low 16 KiB
      e.exc = fetch_pkg::INSTR_ACCESS_FAULT;
    end else if (pc[31:3] == ERR_ADDR[31:3]) begin
      e.exc = fetch_pkg::INSTR_ACCESS_FAULT;
    end else begin
      e.instr = mem_word(pc);
      e.exc   = decode_exc(e.instr);
    end
    return e;
  endfunction

  // ============================================================
  // APB memory model with random wait states
  // ============================================================
  initial begin : apb_memory
    int unsigned         wait_left;
    fetch_pkg::apb_req_t prev_req;
    logic                prev_rdy;
    prev_req  = '0;
    prev_rdy  = 1'b0;
    wait_left = $urandom(RNG_SEED) % 3;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        apb_rsp  <= '0;
        prev_req = '0;
        prev_rdy = 1'b0;
      end else begin
        // Setup or an unfinished access must lead to an access at the same address
        if (prev_req.psel && (!prev_req.penable || !prev_rdy)) begin
          if (!(apb_req.psel && apb_req.penable) || (apb_req.paddr != prev_req.paddr)) begin
            $display("Error: APB transfer at %h left its setup or access phase early",
                     prev_req.paddr);
            errors++;
          end
        end else if (apb_req.psel && apb_req.penable) begin
          $display("Error: APB access phase at %h without a setup phase", apb_req.paddr);
          errors++;
        end
        prev_req = apb_req;
        prev_rdy = apb_rsp.pready;
        apb_rsp.pready  <= 1'b0;
        apb_rsp.pslverr <= 1'b0;
        // Answer each access phase once
        if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
          if (wait_left == 0) begin
            apb_rsp.pready  <= 1'b1;
            apb_rsp.prdata  <= mem_word(apb_req.paddr);
            apb_rsp.pslverr <= (apb_req.paddr == ERR_ADDR);
            xfer_count++;
            wait_left = $urandom % 3;
          end else begin
            wait_left--;
          end
        end
      end
    end
  end

  // ============================================================
  // Drive, wait and compare
  // ============================================================
  // src bits are flush, trap and redirect
  task automatic load_pc(input logic [2:0] src, input word_t fpc, input word_t tpc,
                         input word_t rpc);
    @(posedge clk);
    flush       <= src[2];
    flush_pc    <= fpc;
    trap        <= src[1];
    mtvec       <= tpc;
    redirect    <= src[0];
    redirect_pc <= rpc;
    @(posedge clk);
    flush    <= 1'b0;
    trap     <= 1'b0;
    redirect <= 1'b0;
  endtask

  task automatic redirect_to(input word_t pc);
    load_pc(3'b001, '0, '0, pc);
  endtask

  // Release stall for one edge so the held PC moves on by 4
  task automatic step_pc();
    @(posedge clk);
    stall <= 1'b0;
    @(posedge clk);
    stall <= 1'b1;
  endtask

  task automatic wait_fetch(output fetch_pkg::fetch_out_t got);
    int cycles;
    cycles = 0;
    got    = '0;
    @(negedge clk);
    while (!out.valid && (cycles < WAIT_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    if (out.valid) begin
      got = out;
    end else begin
      $display("Error: no valid fetch output within %0d cycles", WAIT_LIMIT);
      errors++;
    end
  endtask

  function automatic string out_text(input fetch_pkg::fetch_out_t o);
    return $sformatf("valid=%b pc=%h instr=%h exc=%0d", o.valid, o.pc, o.instr, o.exc);
  endfunction

  task automatic check_out(input string name, input fetch_pkg::fetch_out_t exp,
                           input fetch_pkg::fetch_out_t act);
    checks++;
    if (act !== exp) begin
      $display("Mismatch %s: expected %s, actual %s", name, out_text(exp), out_text(act));
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      $display("Mismatch %s: expected %0d transfers, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic fetch_and_check(input string name, input word_t pc);
    fetch_pkg::fetch_out_t got;
    wait_fetch(got);
    check_out(name, expect_fetch(pc), got);
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("Test %s done, no errors", name);
    end else begin
      $display("Test %s done, %0d errors", name, errors - err_before);
    end
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic test_reset_sequence();
    int err0;
    err0 = errors;
    for (int i = 0; i < 3; i++) begin
      if (i > 0) begin
        step_pc();
      end
      fetch_and_check("reset_sequence", fetch_pkg::RESET_VECTOR + 4 * i);
    end
    report_test("reset_sequence", err0);
  endtask

  // Later passes over lines 0x200 and 0x208 must all hit
  task automatic test_loop_fills();
    int err0;
    int base;
    err0 = errors;
    base = xfer_count;
    for (int pass = 0; pass < 3; pass++) begin
      redirect_to(32'h0000_0200);
      fetch_and_check("loop_fills", 32'h0000_0200);
      step_pc();
      fetch_and_check("loop_fills", 32'h0000_0204);
      step_pc();
      fetch_and_check("loop_fills", 32'h0000_0208);
      if (pass == 0) begin
        check_count("loop_fills first pass", 2 * fetch_pkg::LINE_WORDS, xfer_count - base);
      end else begin
        check_count("loop_fills repeat pass", 0, xfer_count - base);
      end
      base = xfer_count;
    end
    report_test("loop_fills", err0);
  endtask

  task automatic test_set_eviction();
    int    err0;
    int    base;
    word_t first;
    err0  = errors;
    first = 32'h0000_0420;
    // Three tags in set 4 so the third fill reuses way 0
    for (int i = 0; i < 3; i++) begin
      base = xfer_count;
      redirect_to(first + SET_STRIDE * i);
      fetch_and_check("set_eviction fill", first + SET_STRIDE * i);
      check_count("set_eviction fill", fetch_pkg::LINE_WORDS, xfer_count - base);
    end
    base = xfer_count;
    redirect_to(first + SET_STRIDE * 2);
    fetch_and_check("set_eviction newest", first + SET_STRIDE * 2);
    check_count("set_eviction newest hit", 0, xfer_count - base);
    // Round-robin keeps the second line in way 1
    base = xfer_count;
    redirect_to(first + SET_STRIDE);
    fetch_and_check("set_eviction middle", first + SET_STRIDE);
    check_count("set_eviction middle hit", 0, xfer_count - base);
    base = xfer_count;
    redirect_to(first);
    fetch_and_check("set_eviction revisit", first);
    check_count("set_eviction revisit", fetch_pkg::LINE_WORDS, xfer_count - base);
    report_test("set_eviction", err0);
  endtask

  task automatic test_pc_priority();
    int err0;
    err0 = errors;
    load_pc(3'b111, 32'h0000_0140, 32'h0000_0180, 32'h0000_01c0);
    fetch_and_check("pc_priority flush", 32'h0000_0140);
    load_pc(3'b011, 32'h0000_0140, 32'h0000_0180, 32'h0000_01c0);
    fetch_and_check("pc_priority trap", 32'h0000_0180);
    report_test("pc_priority", err0);
  endtask

  task automatic test_exceptions();
    int err0;
    int base;
    err0 = errors;
    redirect_to(32'h0000_0302);
    fetch_and_check("exceptions misaligned", 32'h0000_0302);
    base = xfer_count;
    redirect_to(32'h0000_8000);
    fetch_and_check("exceptions region", 32'h0000_8000);
    // Long enough for a stray fill to finish its first transfer
    repeat (4 * fetch_pkg::LINE_WORDS * 2) @(negedge clk);
    check_count("exceptions region traffic", 0, xfer_count - base);
    redirect_to(ERR_ADDR);
    fetch_and_check("exceptions bus error", ERR_ADDR);
    redirect_to(ECALL_ADDR);
    fetch_and_check("exceptions ecall", ECALL_ADDR);
    redirect_to(EBREAK_ADDR);
    fetch_and_check("exceptions ebreak", EBREAK_ADDR);
    redirect_to(C16_ADDR);
    fetch_and_check("exceptions 16-bit", C16_ADDR);
    report_test("exceptions", err0);
  endtask

  task automatic test_stall_hold();
    int                    err0;
    int                    base;
    fetch_pkg::fetch_out_t held;
    err0 = errors;
    redirect_to(32'h0000_0200);
    wait_fetch(held);
    check_out("stall_hold first", expect_fetch(32'h0000_0200), held);
    base = xfer_count;
    repeat (4) begin
      @(negedge clk);
      check_out("stall_hold repeat", expect_fetch(32'h0000_0200), out);
    end
    check_count("stall_hold traffic", 0, xfer_count - base);
    report_test("stall_hold", err0);
  endtask

  // ============================================================
  // Sequence and watchdog
  // ============================================================
  initial begin : main
    stall       = 1'b1;
    flush       = 1'b0;
    flush_pc    = '0;
    trap        = 1'b0;
    mtvec       = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    @(posedge rst_n);
    test_reset_sequence();
    test_loop_fills();
    test_set_eviction();
    test_pc_priority();
    test_exceptions();
    test_stall_hold();
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire
